// File: enc_defines.svh
`ifndef ENC_DEFINES_SVH
`define ENC_DEFINES_SVH

// Data and symbol widths
`define BYTE_W 8
`define SYM_W 10

// Sub-blocks of a symbol, abcdei then fghj
`define SIX_W 6
`define FOUR_W 4

// Symbol FIFO
`define SYM_FIFO_DEPTH 8
`define SYM_FIFO_AW 3

`endif

// File: link_pkg.sv
`default_nettype none

`include "enc_defines.svh"

package link_pkg;

	// Host data byte
	typedef logic [`BYTE_W-1:0] byte_t;

	// Extra msb tells full from empty
	typedef logic [`SYM_FIFO_AW:0] fifo_ptr_t;

	// Bit position within a symbol, 0 to 9
	typedef logic [3:0] bit_cnt_t;

endpackage

`default_nettype wire

// File: line_code_pkg.sv
`default_nettype none

`include "enc_defines.svh"

package line_code_pkg;

	typedef enum logic {
		RD_NEG = 1'b0,
		RD_POS = 1'b1
	} rd_e;

	typedef logic [`SIX_W-1:0] six_t;
	typedef logic [`FOUR_W-1:0] four_t;

	typedef struct packed {
		six_t abcdei;
		four_t fghj;
	} sub_blocks_t;

	// Flat word for the line, sub-block pair for the encoder
	typedef union packed {
		logic [`SYM_W-1:0] word;
		sub_blocks_t blk;
	} symbol_u;

	////////////////////////////////////////
	// Disparity of a sub-block
	function automatic logic sub_block_flips(input logic [`SIX_W-1:0] bits, input int width);
		int ones;
		ones = 0;
		for (int i = 0; i < `SIX_W; i++)
			ones += int'(bits[i]);
		return (2 * ones) != width;
	endfunction

	////////////////////////////////////////
	// 5b/6b, table holds the RD- words
	function automatic six_t encode_6b(input logic [4:0] x, input rd_e rd);
		six_t code;
		case (x)
			5'd0: code = 6'b100111;
			5'd1: code = 6'b011101;
			5'd2: code = 6'b101101;
			5'd3: code = 6'b110001;
			5'd4: code = 6'b110101;
			5'd5: code = 6'b101001;
			5'd6: code = 6'b011001;
			5'd7: code = 6'b111000;
			5'd8: code = 6'b111001;
			5'd9: code = 6'b100101;
			5'd10: code = 6'b010101;
			5'd11: code = 6'b110100;
			5'd12: code = 6'b001101;
			5'd13: code = 6'b101100;
			5'd14: code = 6'b011100;
			5'd15: code = 6'b010111;
			5'd16: code = 6'b011011;
			5'd17: code = 6'b100011;
			5'd18: code = 6'b010011;
			5'd19: code = 6'b110010;
			5'd20: code = 6'b001011;
			5'd21: code = 6'b101010;
			5'd22: code = 6'b011010;
			5'd23: code = 6'b111010;
			5'd24: code = 6'b110011;
			5'd25: code = 6'b100110;
			5'd26: code = 6'b010110;
			5'd27: code = 6'b110110;
			5'd28: code = 6'b001110;
			5'd29: code = 6'b101110;
			5'd30: code = 6'b011110;
			default: code = 6'b101011;
		endcase
		// RD+ is the complement for unbalanced words and for D.7
		if (rd == RD_POS && (sub_block_flips(code, `SIX_W) || x == 5'd7))
			code = ~code;
		return code;
	endfunction

	////////////////////////////////////////
	// 3b/4b, primary D.x.7 only
	function automatic four_t encode_4b(input logic [2:0] y, input rd_e rd);
		four_t code;
		case (y)
			3'd0: code = 4'b1011;
			3'd1: code = 4'b1001;
			3'd2: code = 4'b0101;
			3'd3: code = 4'b1100;
			3'd4: code = 4'b1101;
			3'd5: code = 4'b1010;
			3'd6: code = 4'b0110;
			default: code = 4'b1110;
		endcase
		// D.x.3 is balanced but still alternates
		if (rd == RD_POS && (sub_block_flips({2'b00, code}, `FOUR_W) || y == 3'd3))
			code = ~code;
		return code;
	endfunction

endpackage

`default_nettype wire

// File: line_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_defines.svh"

module line_encoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire link_pkg::byte_t wb_dat,
	output logic wb_ack,
	output logic push,
	output line_code_pkg::symbol_u symbol,
	input wire logic full
);

	line_code_pkg::rd_e rd;
	line_code_pkg::rd_e rd_mid;
	line_code_pkg::rd_e rd_end;
	line_code_pkg::six_t six;
	line_code_pkg::four_t four;

	// Fresh request only, the ack cycle never accepts
	assign push = wb_cyc && wb_stb && !full && !wb_ack;

	////////////////////////////////////////
	// Symbol assembly
	always_comb begin
		six = line_code_pkg::encode_6b(wb_dat[4:0], rd);
		if (line_code_pkg::sub_block_flips(six, `SIX_W))
			rd_mid = line_code_pkg::rd_e'(~rd);
		else
			rd_mid = rd;

		// fghj picks its column from the disparity after abcdei
		four = line_code_pkg::encode_4b(wb_dat[7:5], rd_mid);
		if (line_code_pkg::sub_block_flips({2'b00, four}, `FOUR_W))
			rd_end = line_code_pkg::rd_e'(~rd_mid);
		else
			rd_end = rd_mid;

		symbol.blk.abcdei = six;
		symbol.blk.fghj = four;
	end

	////////////////////////////////////////
	// Ack and running disparity
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			rd <= line_code_pkg::RD_NEG;
		end else begin
			wb_ack <= push;
			if (push)
				rd <= rd_end;
		end
	end

endmodule

`default_nettype wire

// File: symbol_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_defines.svh"

module symbol_fifo (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire line_code_pkg::symbol_u wr_symbol,
	output logic full,
	input wire logic pop,
	output line_code_pkg::symbol_u rd_symbol,
	output logic valid
);

	line_code_pkg::symbol_u mem [`SYM_FIFO_DEPTH];
	link_pkg::fifo_ptr_t wr_ptr;
	link_pkg::fifo_ptr_t rd_ptr;
	logic do_push;
	logic do_pop;

	// Same slot, other lap
	assign full = (wr_ptr[`SYM_FIFO_AW] != rd_ptr[`SYM_FIFO_AW]) &&
		(wr_ptr[`SYM_FIFO_AW-1:0] == rd_ptr[`SYM_FIFO_AW-1:0]);
	assign valid = wr_ptr != rd_ptr;

	assign do_push = push && !full;
	assign do_pop = pop && valid;

	// Head entry, read without a register
	assign rd_symbol = mem[rd_ptr[`SYM_FIFO_AW-1:0]];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[`SYM_FIFO_AW-1:0]] <= wr_symbol;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: symbol_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_defines.svh"

module symbol_serializer (
	input wire logic clk,
	input wire logic rst,
	input wire line_code_pkg::symbol_u symbol,
	input wire logic valid,
	output logic pop,
	output logic ser_out,
	output logic ser_valid
);

	logic [`SYM_W-1:0] shreg;
	link_pkg::bit_cnt_t cnt;
	logic busy;
	logic last;

	assign last = busy && (cnt == link_pkg::bit_cnt_t'(`SYM_W - 1));

	// Take the next symbol while bit j goes out, so no gap
	assign pop = valid && (!busy || last);

	assign ser_valid = busy;
	assign ser_out = busy && shreg[`SYM_W-1];

	////////////////////////////////////////
	// Shift register, bit a first
	always_ff @(posedge clk) begin
		if (pop)
			shreg <= symbol.word;
		else
			shreg <= {shreg[`SYM_W-2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (pop) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: serdes_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_tx_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire link_pkg::byte_t wb_dat,
	output logic wb_ack,
	output logic ser_out,
	output logic ser_valid
);

	logic push;
	logic full;
	logic pop;
	logic fifo_valid;
	line_code_pkg::symbol_u enc_symbol;
	line_code_pkg::symbol_u fifo_symbol;

	line_encoder i_encoder (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.push(push),
		.symbol(enc_symbol),
		.full(full)
	);

	symbol_fifo i_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.wr_symbol(enc_symbol),
		.full(full),
		.pop(pop),
		.rd_symbol(fifo_symbol),
		.valid(fifo_valid)
	);

	symbol_serializer i_serializer (
		.clk(clk),
		.rst(rst),
		.symbol(fifo_symbol),
		.valid(fifo_valid),
		.pop(pop),
		.ser_out(ser_out),
		.ser_valid(ser_valid)
	);

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS = 40.0
) (
	output logic clk
);

	// First edge is a rising one, half a period in
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "enc_defines.svh"

module tb_top;

	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_LIMIT = 400;
	localparam int RANDOM_BYTES = 300;
	localparam int BURST_BYTES = 30;

	// abcdei words in the RD- and RD+ columns
	localparam logic [5:0] SIX_NEG [0:31] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [5:0] SIX_POS [0:31] = '{
		6'b011000, 6'b100010, 6'b010010, 6'b110001, 6'b001010, 6'b101001, 6'b011001, 6'b000111,
		6'b000110, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b101000,
		6'b100100, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b000101,
		6'b001100, 6'b100110, 6'b010110, 6'b001001, 6'b001110, 6'b010001, 6'b100001, 6'b010100
	};

	// fghj words with the primary D.x.7
	localparam logic [3:0] FOUR_NEG [0:7] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};
	localparam logic [3:0] FOUR_POS [0:7] = '{
		4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b0001
	};

	logic clk;
	logic rst = 1'b1;
	logic wb_cyc;
	logic wb_stb;
	link_pkg::byte_t wb_dat;
	logic wb_ack;
	logic ser_out;
	logic ser_valid;

	logic [`SYM_W-1:0] exp_q [$];
	logic model_rd;
	logic [`SYM_W-1:0] rx_sym;
	logic [`SYM_W-1:0] rx_exp;
	int rx_bits = 0;
	int last_wait;

	tb_clock #(.PERIOD_NS(40.0)) i_clock (
		.clk(clk)
	);

	serdes_tx_top i_dut (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.ser_out(ser_out),
		.ser_valid(ser_valid)
	);

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
	endtask

	////////////////////////////////////////
	// Reference encoder where model_rd low means RD-
	function automatic logic [`SYM_W-1:0] ref_symbol(input link_pkg::byte_t b, input logic rd_in,
			output logic rd_out);
		logic [5:0] six;
		logic [3:0] four;
		logic rd_mid;
		six = rd_in ? SIX_POS[b[4:0]] : SIX_NEG[b[4:0]];
		// Balanced sub-block keeps the disparity
		if ($countones(six) == 3)
			rd_mid = rd_in;
		else
			rd_mid = $countones(six) > 3;
		four = rd_mid ? FOUR_POS[b[7:5]] : FOUR_NEG[b[7:5]];
		if ($countones(four) == 2)
			rd_out = rd_mid;
		else
			rd_out = $countones(four) > 2;
		return {six, four};
	endfunction

	// D.x.y as a byte
	function automatic link_pkg::byte_t d_code(input int x, input int y);
		return link_pkg::byte_t'((y << 5) | x);
	endfunction

	task automatic check_quiet();
		assert (wb_ack === 1'b0) else begin
			report_error($sformatf("MISMATCH wb_ack: expected 0x0 got 0x%h", wb_ack));
			$fatal(1);
		end
		assert (ser_valid === 1'b0) else begin
			report_error($sformatf("MISMATCH ser_valid: expected 0x0 got 0x%h", ser_valid));
			$fatal(1);
		end
	endtask

	////////////////////////////////////////
	// Host write entered just after a falling edge
	task automatic write_byte(input link_pkg::byte_t b);
		logic [`SYM_W-1:0] sym;
		logic rd_next;
		int waited;
		sym = ref_symbol(b, model_rd, rd_next);
		exp_q.push_back(sym);
		model_rd = rd_next;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_dat = b;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			assert (waited <= WAIT_LIMIT) else begin
				report_error($sformatf("no wb_ack for byte 0x%h after %0d cycles", b, WAIT_LIMIT));
				$fatal(1);
			end
		end while (!wb_ack);
		last_wait = waited;
	endtask

	task automatic idle_cycles(input int n);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_drained();
		int cycles;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			cycles++;
			assert (cycles <= DRAIN_LIMIT) else begin
				report_error("expected symbols never came out of the serializer");
				$fatal(1);
			end
		end
		// Line must go idle within one symbol time
		cycles = 0;
		while (ser_valid) begin
			@(negedge clk);
			cycles++;
			assert (cycles <= `SYM_W) else begin
				report_error("ser_valid still high 10 cycles after the last symbol");
				$fatal(1);
			end
		end
	endtask

	////////////////////////////////////////
	// Bit collector and comparison
	always @(negedge clk) begin
		if (rst) begin
			rx_bits = 0;
		end else if (ser_valid) begin
			rx_sym = {rx_sym[`SYM_W-2:0], ser_out};
			rx_bits++;
			if (rx_bits == `SYM_W) begin
				rx_bits = 0;
				assert (exp_q.size() != 0) else begin
					report_error($sformatf("symbol 0x%h arrived with none expected", rx_sym));
					$fatal(1);
				end
				assert ($countones(rx_sym) inside {4, 5, 6}) else begin
					report_error($sformatf("symbol 0x%h is not DC balanced", rx_sym));
					$fatal(1);
				end
				rx_exp = exp_q.pop_front();
				assert (rx_sym == rx_exp) else begin
					report_error($sformatf("MISMATCH ser_out symbol: expected 0x%h got 0x%h",
						rx_exp, rx_sym));
					$fatal(1);
				end
			end
		end else begin
			assert (ser_out == 1'b0) else begin
				report_error($sformatf("MISMATCH ser_out: expected 0x0 got 0x%h", ser_out));
				$fatal(1);
			end
		end
	end

	initial begin
		int gap;
		bit stalled;
		void'($urandom(32'h30eb));
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_dat = '0;
		model_rd = 1'b0;
		last_wait = 0;
		repeat (16) begin
			@(negedge clk);
			check_quiet();
		end
		rst = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_quiet();
		end

		// Directed code words
		write_byte(d_code(0, 0));
		write_byte(d_code(3, 0));
		write_byte(d_code(7, 0));
		write_byte(d_code(3, 3));
		write_byte(d_code(7, 7));
		write_byte(d_code(23, 4));
		write_byte(d_code(28, 5));
		write_byte(d_code(31, 7));
		write_byte(d_code(10, 2));
		wait_drained();

		for (int i = 0; i < RANDOM_BYTES; i++) begin
			gap = int'($urandom % 13);
			write_byte(link_pkg::byte_t'($urandom));
			idle_cycles(gap);
		end
		wait_drained();

		// Burst faster than the line
		stalled = 1'b0;
		for (int i = 0; i < BURST_BYTES; i++) begin
			write_byte(link_pkg::byte_t'($urandom));
			// Two cycles per write when the FIFO has room
			if (last_wait > 2)
				stalled = 1'b1;
		end
		assert (stalled) else begin
			report_error("burst of writes never stalled on wb_ack");
			$fatal(1);
		end
		wait_drained();

		// Restart after a quiet line
		idle_cycles(25);
		write_byte(d_code(23, 4));
		write_byte(d_code(3, 3));
		write_byte(d_code(7, 7));
		wait_drained();
		idle_cycles(5);

		if (exp_q.size() == 0 && rx_bits == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			report_error("symbols left over at the end of the run");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
link_pkg.sv
line_code_pkg.sv
line_encoder.sv
symbol_fifo.sv
symbol_serializer.sv
serdes_tx_top.sv
tb_clock.sv
tb_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
